/* bch_macros.svh */
`ifndef BCH_MACROS_SVH
`define BCH_MACROS_SVH

// ==========================================================================
// BCH(15,5) code over GF(2^4)
// ==========================================================================

// field width in bits
`define BCH_M 4

// code length, 2^M - 1
`define BCH_N 15

// correctable errors
`define BCH_T 3

// message bits
`define BCH_K 5

// x^4 + x + 1
`define BCH_POLY 5'h13

// locator degree width, holds 0..T
`define BCH_LW 2

`endif

/* gf_pkg.sv */
`default_nettype none
`include "bch_macros.svh"

package gf_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	// coefficient 0 in the lowest element
	typedef gf_elem_t [`BCH_T:0] gf_poly_t;

	// S1 in element 0 up to S2t
	typedef gf_elem_t [2*`BCH_T-1:0] syn_vec_t;

	localparam logic [`BCH_M:0] GF_POLY = `BCH_POLY;
	localparam gf_elem_t GF_ALPHA = gf_elem_t'(2);

	// shift-and-add product, reduced on every shift
	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			if (sh[`BCH_M-1])
				sh = (sh << 1) ^ GF_POLY[`BCH_M-1:0];
			else
				sh = sh << 1;
		end
		return acc;
	endfunction

	// alpha^e, exponent taken modulo the group order
	function automatic gf_elem_t gf_alpha_pow(input int e);
		gf_elem_t r;
		int k;
		r = gf_elem_t'(1);
		k = e % `BCH_N;
		for (int i = 0; i < `BCH_N; i++) begin
			if (i < k)
				r = gf_mul(r, GF_ALPHA);
		end
		return r;
	endfunction

endpackage

`default_nettype wire

/* bch_pkg.sv */
`default_nettype none
`include "bch_macros.svh"

package bch_pkg;

	// bit j is the coefficient of x^j
	typedef logic [`BCH_N-1:0] codeword_t;

	// decode -> execute
	typedef struct packed {
		codeword_t word;
		gf_pkg::syn_vec_t syndromes;
	} syn_bundle_t;

	// execute -> result
	typedef struct packed {
		codeword_t word;
		gf_pkg::gf_poly_t sigma;
		logic [`BCH_LW-1:0] degree;
	} key_bundle_t;

	typedef struct packed {
		logic [`BCH_LW-1:0] err_count;
		logic uncorrectable;
	} dec_status_t;

endpackage

`default_nettype wire

/* bch_syndrome.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bch_macros.svh"

module bch_syndrome (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire bch_pkg::codeword_t codeword,
	output logic ready,
	output logic syn_done,
	output bch_pkg::syn_bundle_t syn_out
);

	localparam logic [`BCH_M-1:0] LAST_STEP = `BCH_M'(`BCH_N - 1);

	logic busy;
	logic [`BCH_M-1:0] step;
	bch_pkg::codeword_t shreg;
	bch_pkg::codeword_t shreg_next;
	gf_pkg::gf_elem_t [`BCH_T-1:0] acc;
	gf_pkg::gf_elem_t [`BCH_T-1:0] acc_next;
	gf_pkg::syn_vec_t syn_full;

	assign ready = !busy;

	// rotate rather than shift, the word is back in place after N steps
	assign shreg_next = {shreg[`BCH_N-2:0], shreg[`BCH_N-1]};

	// ======================================================================
	// Horner step on the odd syndromes, top bit first
	// ======================================================================
	always_comb begin
		for (int i = 0; i < `BCH_T; i++) begin
			acc_next[i] = gf_pkg::gf_mul(acc[i], gf_pkg::gf_alpha_pow(2 * i + 1))
				^ gf_pkg::gf_elem_t'(shreg[`BCH_N-1]);
		end
		// even ones are squares of lower ones
		for (int k = 1; k <= 2 * `BCH_T; k++) begin
			if (k % 2 == 1)
				syn_full[k-1] = acc_next[(k-1)/2];
			else
				syn_full[k-1] = gf_pkg::gf_mul(syn_full[k/2-1], syn_full[k/2-1]);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
			syn_done <= 1'b0;
			syn_out <= '0;
		end else begin
			syn_done <= 1'b0;
			if (start && !busy) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == LAST_STEP) begin
					busy <= 1'b0;
					syn_done <= 1'b1;
					syn_out.word <= shreg_next;
					syn_out.syndromes <= syn_full;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start && !busy) begin
			shreg <= codeword;
			acc <= '0;
		end else if (busy) begin
			shreg <= shreg_next;
			acc <= acc_next;
		end
	end

	// an accepted word leaves the stage a fixed time later
	a_syn_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start && ready |-> ##(`BCH_N + 1) syn_done);

endmodule

`default_nettype wire

/* bch_key_bma.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bch_macros.svh"

module bch_key_bma (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire bch_pkg::syn_bundle_t syn_in,
	output logic key_done,
	output bch_pkg::key_bundle_t key_out
);

	localparam logic [`BCH_LW-1:0] LAST_ITER = `BCH_LW'(`BCH_T - 1);
	localparam logic [`BCH_LW:0] L_MAX = (`BCH_LW + 1)'(`BCH_T + 1);

	// control
	logic busy;
	logic shuffle;
	logic [`BCH_LW-1:0] r;
	logic [`BCH_LW:0] l;

	// datapath
	bch_pkg::codeword_t word;
	gf_pkg::gf_poly_t sigma;
	gf_pkg::gf_poly_t beta;
	gf_pkg::gf_poly_t win;
	gf_pkg::syn_vec_t que;
	gf_pkg::gf_elem_t d_r;
	gf_pkg::gf_elem_t d_p;

	gf_pkg::gf_elem_t d_r_next;
	gf_pkg::gf_poly_t sigma_next;
	logic bsel;
	logic [`BCH_LW:0] l_new;
	logic [`BCH_LW:0] l_upd;
	logic overflow;

	// ======================================================================
	// discrepancy and update terms
	// ======================================================================

	// d_r = sum of sigma_i * S(2r+1-i), window already lined up
	always_comb begin
		d_r_next = '0;
		for (int i = 0; i <= `BCH_T; i++)
			d_r_next = d_r_next ^ gf_pkg::gf_mul(sigma[i], win[i]);
	end

	// sigma(r+1) = d_p * sigma(r) + d_r * beta(r)
	always_comb begin
		for (int i = 0; i <= `BCH_T; i++)
			sigma_next[i] = gf_pkg::gf_mul(d_p, sigma[i]) ^ gf_pkg::gf_mul(d_r, beta[i]);
	end

	assign bsel = (d_r != '0) && ({1'b0, r} >= l);
	assign l_new = {r, 1'b1} - l;
	assign l_upd = !bsel ? l : ((l_new > L_MAX) ? L_MAX : l_new);

	// too many errors, pass a zero locator so the search rejects the word
	assign overflow = l_upd > (`BCH_LW + 1)'(`BCH_T);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			shuffle <= 1'b0;
			r <= '0;
			l <= '0;
			key_done <= 1'b0;
			key_out <= '0;
		end else begin
			key_done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				shuffle <= 1'b0;
				r <= '0;
				l <= '0;
			end else if (busy) begin
				shuffle <= !shuffle;
				if (shuffle) begin
					r <= r + 1'b1;
					l <= l_upd;
					if (r == LAST_ITER) begin
						busy <= 1'b0;
						key_done <= 1'b1;
						key_out.word <= word;
						key_out.sigma <= overflow ? '0 : sigma_next;
						key_out.degree <= l_upd[`BCH_LW-1:0];
					end
				end
			end
		end
	end

	// first pass turns these into 1 + S1 x, beta x^2 or x^3
	always_ff @(posedge clk) begin
		if (start) begin
			word <= syn_in.word;
			sigma <= gf_pkg::gf_poly_t'(1);
			beta <= gf_pkg::gf_poly_t'(1 << `BCH_M);
			d_r <= '0;
			d_p <= gf_pkg::gf_elem_t'(1);
			win <= gf_pkg::gf_poly_t'(syn_in.syndromes[0]);
			que <= syn_in.syndromes >> `BCH_M;
		end else if (busy && !shuffle) begin
			d_r <= d_r_next;
		end else if (busy) begin
			sigma <= sigma_next;
			if (bsel)
				d_p <= d_r;
			// x^2 times either the old locator or beta
			beta <= {(bsel ? sigma[`BCH_T-2:0] : beta[`BCH_T-2:0]),
				{2{gf_pkg::gf_elem_t'(0)}}};
			// window moves up two syndromes
			win <= {win[1], win[0], que[0], que[1]};
			que <= que >> (2 * `BCH_M);
		end
	end

	a_key_latency: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> ##(2 * `BCH_T + 1) key_done);

	// locator degree bounded by T+1
	a_deg_bound: assert property (@(posedge clk) disable iff (!rst_n)
		l <= L_MAX);

endmodule

`default_nettype wire

/* bch_chien_correct.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bch_macros.svh"

module bch_chien_correct (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire bch_pkg::key_bundle_t key_in,
	output logic done,
	output bch_pkg::codeword_t corrected,
	output bch_pkg::dec_status_t status
);

	localparam logic [`BCH_M-1:0] LAST_STEP = `BCH_M'(`BCH_N - 1);

	logic busy;
	logic [`BCH_M-1:0] step;

	gf_pkg::gf_poly_t coef;
	bch_pkg::codeword_t recv;
	bch_pkg::codeword_t work;
	logic [`BCH_LW-1:0] degree;
	logic [`BCH_M-1:0] roots;

	gf_pkg::gf_elem_t sum;
	logic hit;
	bch_pkg::codeword_t work_next;
	logic [`BCH_M-1:0] roots_next;
	logic unc;

	// ======================================================================
	// sigma(alpha^-j), one position per cycle
	// ======================================================================
	always_comb begin
		sum = '0;
		for (int i = 0; i <= `BCH_T; i++)
			sum = sum ^ coef[i];
	end

	assign hit = (sum == '0);
	assign work_next = hit ? (work ^ (bch_pkg::codeword_t'(1) << step)) : work;
	assign roots_next = roots + {{(`BCH_M - 1){1'b0}}, hit};

	// a zero locator hits every position, so it fails here as well
	assign unc = roots_next != {{(`BCH_M - `BCH_LW){1'b0}}, degree};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
			done <= 1'b0;
			corrected <= '0;
			status <= '0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				step <= '0;
			end else if (busy) begin
				step <= step + 1'b1;
				if (step == LAST_STEP) begin
					busy <= 1'b0;
					done <= 1'b1;
					// failed words go out as received
					corrected <= unc ? recv : work_next;
					status.err_count <= unc ? '0 : degree;
					status.uncorrectable <= unc;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			coef <= key_in.sigma;
			recv <= key_in.word;
			work <= key_in.word;
			degree <= key_in.degree;
			roots <= '0;
		end else if (busy) begin
			// term i steps by alpha^-i
			for (int i = 0; i <= `BCH_T; i++)
				coef[i] <= gf_pkg::gf_mul(coef[i], gf_pkg::gf_alpha_pow(`BCH_N - i));
			work <= work_next;
			roots <= roots_next;
		end
	end

	// no back-pressure, upstream spacing must keep this stage free
	a_not_busy: assert property (@(posedge clk) disable iff (!rst_n)
		start |-> !busy);

endmodule

`default_nettype wire

/* bch_decoder_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bch_decoder_top (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic start,
	input wire bch_pkg::codeword_t codeword,
	output logic ready,
	output logic done,
	output bch_pkg::codeword_t corrected,
	output bch_pkg::dec_status_t status
);

	logic syn_done;
	bch_pkg::syn_bundle_t syn_bus;
	logic key_done;
	bch_pkg::key_bundle_t key_bus;

	// decode
	bch_syndrome u_syndrome (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.codeword(codeword),
		.ready(ready),
		.syn_done(syn_done),
		.syn_out(syn_bus)
	);

	// execute
	bch_key_bma u_key (
		.clk(clk),
		.rst_n(rst_n),
		.start(syn_done),
		.syn_in(syn_bus),
		.key_done(key_done),
		.key_out(key_bus)
	);

	// result
	bch_chien_correct u_chien (
		.clk(clk),
		.rst_n(rst_n),
		.start(key_done),
		.key_in(key_bus),
		.done(done),
		.corrected(corrected),
		.status(status)
	);

endmodule

`default_nettype wire

/* tb_bch_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "bch_macros.svh"

module tb_bch_decoder;

	localparam int CLK_PERIOD = 4;
	localparam int RESET_CYCLES = 5;
	localparam int LATENCY = 39;
	localparam int SPACING = 16;
	localparam int DONE_TIMEOUT = 100;
	localparam int TRIALS = 10;
	localparam int BURST = 8;
	// clean + singles + two/three + four + burst + reset pair
	localparam int NUM_DECODES = 1 + `BCH_N + 3 * TRIALS + BURST + 2;
	localparam int WATCHDOG_CYCLES = NUM_DECODES * 40 + 500;
	// x^10+x^8+x^5+x^4+x^2+x+1
	localparam logic [`BCH_N-`BCH_K:0] GEN_POLY = 11'h537;

	logic clk = 1'b0;
	logic rst_n;
	logic start;
	bch_pkg::codeword_t codeword;
	logic ready;
	logic done;
	bch_pkg::codeword_t corrected;
	bch_pkg::dec_status_t status;

	int cycle = 0;
	int check_count = 0;
	int error_count = 0;

	bch_decoder_top uut (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.codeword(codeword),
		.ready(ready),
		.done(done),
		.corrected(corrected),
		.status(status)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	always @(posedge clk) cycle <= cycle + 1;

	// ======================================================================
	// reference model and helpers
	// ======================================================================
	task automatic expect_equal(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
		end
	endtask

	// remainder modulo the generator, zero for a codeword
	function automatic logic [`BCH_N-`BCH_K-1:0] parity_remainder(input bch_pkg::codeword_t w);
		bch_pkg::codeword_t r;
		r = w;
		for (int i = `BCH_N - 1; i >= `BCH_N - `BCH_K; i--) begin
			if (r[i])
				r = r ^ (bch_pkg::codeword_t'(GEN_POLY) << (i - (`BCH_N - `BCH_K)));
		end
		return r[`BCH_N-`BCH_K-1:0];
	endfunction

	// systematic, message in the top bits
	task automatic encode_word(input logic [`BCH_K-1:0] msg, output bch_pkg::codeword_t cw);
		bch_pkg::codeword_t shifted;
		shifted = {msg, {(`BCH_N - `BCH_K){1'b0}}};
		cw = shifted | bch_pkg::codeword_t'(parity_remainder(shifted));
	endtask

	task automatic random_codeword(output bch_pkg::codeword_t cw);
		logic [31:0] rnd;
		rnd = $urandom;
		encode_word(rnd[`BCH_K-1:0], cw);
	endtask

	// n distinct bit positions
	function automatic bch_pkg::codeword_t error_mask(input int n);
		bch_pkg::codeword_t m;
		int pos;
		m = '0;
		while ($countones(m) < n) begin
			pos = $urandom % `BCH_N;
			m = m | (bch_pkg::codeword_t'(1) << pos);
		end
		return m;
	endfunction

	task automatic send_word(input bch_pkg::codeword_t w, output int start_cycle);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!ready && waited < DONE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		if (!ready) begin
			error_count++;
			$display("ready stayed low for %0d cycles at %0t", DONE_TIMEOUT, $time);
		end
		start = 1'b1;
		codeword = w;
		start_cycle = cycle;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic wait_done(output int done_cycle);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!done && waited < DONE_TIMEOUT) begin
			@(negedge clk);
			waited++;
		end
		done_cycle = cycle;
		if (!done) begin
			error_count++;
			$display("no done pulse within %0d cycles at %0t", DONE_TIMEOUT, $time);
		end
	endtask

	task automatic decode_word(input bch_pkg::codeword_t rx, output bch_pkg::codeword_t out,
		output bch_pkg::dec_status_t st, output int latency);
		int t0;
		int t1;
		send_word(rx, t0);
		wait_done(t1);
		out = corrected;
		st = status;
		latency = t1 - t0;
	endtask

	task automatic check_result(input string what, input bch_pkg::codeword_t out,
		input bch_pkg::dec_status_t st, input bch_pkg::codeword_t exp_cw, input int exp_cnt);
		expect_equal({what, " word"}, 32'(out), 32'(exp_cw));
		expect_equal({what, " err_count"}, 32'(st.err_count), exp_cnt);
		expect_equal({what, " uncorrectable"}, 32'(st.uncorrectable), 0);
	endtask

	// ======================================================================
	// directed tests
	// ======================================================================
	task automatic error_free_word();
		bch_pkg::codeword_t cw;
		bch_pkg::codeword_t out;
		bch_pkg::dec_status_t st;
		int lat;
		random_codeword(cw);
		decode_word(cw, out, st, lat);
		check_result("error-free", out, st, cw, 0);
		expect_equal("error-free latency", lat, LATENCY);
	endtask

	task automatic single_errors();
		bch_pkg::codeword_t cw;
		bch_pkg::codeword_t out;
		bch_pkg::dec_status_t st;
		int lat;
		for (int p = 0; p < `BCH_N; p++) begin
			random_codeword(cw);
			decode_word(cw ^ (bch_pkg::codeword_t'(1) << p), out, st, lat);
			check_result($sformatf("single error bit %0d", p), out, st, cw, 1);
		end
	endtask

	task automatic multi_errors();
		bch_pkg::codeword_t cw;
		bch_pkg::codeword_t out;
		bch_pkg::dec_status_t st;
		int lat;
		for (int n = 2; n <= `BCH_T; n++) begin
			for (int k = 0; k < TRIALS; k++) begin
				random_codeword(cw);
				decode_word(cw ^ error_mask(n), out, st, lat);
				check_result($sformatf("%0d errors trial %0d", n, k), out, st, cw, n);
			end
		end
	endtask

	task automatic four_errors();
		bch_pkg::codeword_t cw;
		bch_pkg::codeword_t rx;
		bch_pkg::codeword_t out;
		bch_pkg::dec_status_t st;
		int lat;
		for (int k = 0; k < TRIALS; k++) begin
			random_codeword(cw);
			rx = cw ^ error_mask(4);
			decode_word(rx, out, st, lat);
			if (st.uncorrectable) begin
				expect_equal("four errors, failed word passed through", 32'(out), 32'(rx));
				expect_equal("four errors, failed err_count", 32'(st.err_count), 0);
			end else begin
				// miscorrection onto a neighbouring codeword
				expect_equal("four errors, result is a codeword",
					32'(parity_remainder(out)), 0);
				expect_equal("four errors, result differs", 32'(out != cw), 1);
				expect_equal("four errors, within t of received",
					32'($countones(out ^ rx) <= `BCH_T), 1);
				expect_equal("four errors, err_count", 32'(st.err_count),
					$countones(out ^ rx));
			end
		end
	endtask

	task automatic back_to_back();
		bch_pkg::codeword_t sent [BURST];
		bch_pkg::codeword_t rx [BURST];
		bch_pkg::codeword_t got [BURST];
		bch_pkg::dec_status_t got_st [BURST];
		int n_err [BURST];
		int t_start [BURST];
		int t_done [BURST];
		for (int i = 0; i < BURST; i++) begin
			random_codeword(sent[i]);
			n_err[i] = $urandom % (`BCH_T + 1);
			rx[i] = sent[i] ^ error_mask(n_err[i]);
		end
		fork
			begin
				for (int i = 0; i < BURST; i++)
					send_word(rx[i], t_start[i]);
			end
			begin
				for (int j = 0; j < BURST; j++) begin
					wait_done(t_done[j]);
					got[j] = corrected;
					got_st[j] = status;
				end
			end
		join
		expect_equal("burst first latency", t_done[0] - t_start[0], LATENCY);
		for (int i = 0; i < BURST; i++) begin
			check_result($sformatf("burst word %0d", i), got[i], got_st[i], sent[i], n_err[i]);
			if (i > 0) begin
				expect_equal("burst start spacing", t_start[i] - t_start[i-1], SPACING);
				expect_equal("burst done spacing", t_done[i] - t_done[i-1], SPACING);
			end
		end
	endtask

	task automatic reset_mid_decode();
		bch_pkg::codeword_t cw;
		bch_pkg::codeword_t out;
		bch_pkg::dec_status_t st;
		int t0;
		int lat;
		int seen;
		random_codeword(cw);
		send_word(cw ^ error_mask(2), t0);
		// word sits in the key stage here
		repeat (SPACING + 4) @(negedge clk);
		rst_n = 1'b0;
		seen = 0;
		repeat (RESET_CYCLES) begin
			@(negedge clk);
			if (done)
				seen++;
		end
		rst_n = 1'b1;
		expect_equal("ready after reset release", 32'(ready), 1);
		repeat (LATENCY + 4) begin
			@(negedge clk);
			if (done)
				seen++;
		end
		expect_equal("done pulses after aborted decode", seen, 0);
		random_codeword(cw);
		decode_word(cw ^ error_mask(1), out, st, lat);
		check_result("decode after reset", out, st, cw, 1);
	endtask

	initial begin
		void'($urandom(5174));
		rst_n = 1'b0;
		start = 1'b0;
		codeword = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
		expect_equal("ready after reset", 32'(ready), 1);
		expect_equal("done after reset", 32'(done), 0);
		expect_equal("corrected after reset", 32'(corrected), 0);
		expect_equal("status after reset", 32'(status), 0);
		error_free_word();
		single_errors();
		multi_errors();
		four_errors();
		back_to_back();
		reset_mid_decode();
		@(negedge clk);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+.
gf_pkg.sv
bch_pkg.sv
bch_syndrome.sv
bch_key_bma.sv
bch_chien_correct.sv
bch_decoder_top.sv
tb_bch_decoder.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_bch_decoder
FILELIST  := tb.f
OBJDIR    := obj_dir
LOG       := sim.log
PASS_MSG  := Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
